/* testbench/command_input.txt */
# systime nmsg msg0 msg1 msg2 msg3 msg4 msg5 len ring0 ring1 ring2 ring3 ring4 ring5 gpio
# nmsg and len are decimal, the rest hex; unused byte columns hold 00
00000000 1 00 00 00 00 00 00 4 00 84 84 03 00 00 00
00000005 1 02 00 00 00 00 00 2 01 05 00 00 00 00 00
ffffffff 1 02 00 00 00 00 00 2 01 7f 00 00 00 00 00
00000064 1 02 00 00 00 00 00 3 01 80 64 00 00 00 00
ffffff9c 1 02 00 00 00 00 00 3 01 ff 1c 00 00 00 00
00010203 1 02 00 00 00 00 00 4 01 84 84 03 00 00 00
00200000 1 02 00 00 00 00 00 5 01 81 80 80 00 00 00
80000000 1 02 00 00 00 00 00 6 01 f8 80 80 80 00 00
7fffffff 1 02 00 00 00 00 00 6 01 87 ff ff ff 7f 00
00000000 3 0f 03 01 00 00 00 0 00 00 00 00 00 00 08
00000000 3 0f 00 01 00 00 00 0 00 00 00 00 00 00 09
00000000 4 0f 07 81 48 00 00 0 00 00 00 00 00 00 89
00000000 4 0f 80 05 01 00 00 0 00 00 00 00 00 00 a9
00000000 3 0f 03 00 00 00 00 0 00 00 00 00 00 00 a1
00000000 3 0f 7f 01 00 00 00 0 00 00 00 00 00 00 a1
00000000 3 0f 08 01 00 00 00 0 00 00 00 00 00 00 a1
00000000 4 0f 82 2c 01 00 00 0 00 00 00 00 00 00 a1
00000000 3 0f 01 7f 00 00 00 0 00 00 00 00 00 00 a3
00000000 1 05 00 00 00 00 00 0 00 00 00 00 00 00 a3
00000000 2 05 00 00 00 00 00 4 00 84 84 03 00 00 a3
00000000 1 13 00 00 00 00 00 0 00 00 00 00 00 00 00
00000000 3 0f 02 01 00 00 00 0 00 00 00 00 00 00 00
00000000 1 00 00 00 00 00 00 4 00 84 84 03 00 00 00

/* vlog.f */
source/command_pkg.sv
source/unit_if.sv
source/rsp_if.sv
source/vlq_decoder.sv
source/cmd_dispatcher.sv
source/system_unit.sv
source/gpio_unit.sv
source/vlq_encoder.sv
source/command_top.sv
testbench/command_tb.sv

/* Bender.yml */
package:
  name: command_frontend

sources:
  - source/command_pkg.sv
  - source/unit_if.sv
  - source/rsp_if.sv
  - source/vlq_decoder.sv
  - source/cmd_dispatcher.sv
  - source/system_unit.sv
  - source/gpio_unit.sv
  - source/vlq_encoder.sv
  - source/command_top.sv
  - target: test
    files:
      - testbench/command_tb.sv

/* testbench/command_tb.sv */
`timescale 1ns/1ps

module command_tb import command_pkg::*; ();

	localparam int MAX_VECS     = 32;
	localparam int RESET_CYCLES = 16;

	logic        clk;
	logic        rst_n;
	logic [7:0]  msg_data;
	logic        msg_ready;
	logic        msg_rd_en;
	logic [31:0] systime;
	logic [7:0]  send_ring_data;
	logic        send_ring_wr_en;
	rsp_len_t    send_fifo_data;
	logic        send_fifo_wr_en;
	gpio_t       gpio;

	logic [31:0] v_systime [MAX_VECS];
	int          v_nmsg [MAX_VECS];
	logic [7:0]  v_msg [MAX_VECS][6];
	rsp_len_t    v_len [MAX_VECS];
	logic [7:0]  v_ring [MAX_VECS][6];
	gpio_t       v_gpio [MAX_VECS];
	int          nvec;
	int          limit;
	int          cycles;
	int          checks;
	int          errors;
	logic [7:0]  msg_q [$];  // Message FIFO contents, head is on msg_data.
	logic [7:0]  ring_q [$];
	rsp_len_t    len_q [$];
	logic        pop;

	command_top i_dut (
		.clk, .rst_n, .msg_data, .msg_ready, .msg_rd_en, .systime,
		.send_ring_data, .send_ring_wr_en, .send_fifo_data, .send_fifo_wr_en, .gpio
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// FIFO model. A read strobe seen in a cycle drops the head at the next edge.
	always begin
		@(negedge clk);
		pop = msg_rd_en;
		@(posedge clk);
		#10;
		if (pop && msg_q.size() != 0)
			void'(msg_q.pop_front());
		msg_ready = msg_q.size() != 0;
		msg_data  = (msg_q.size() != 0) ? msg_q[0] : 8'h00;
	end

	always @(negedge clk) begin
		if (send_ring_wr_en)
			ring_q.push_back(send_ring_data);
		if (send_fifo_wr_en)
			len_q.push_back(send_fifo_data);
	end

	initial begin
		cycles = 0;
		@(posedge clk);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not end within %0d cycles", limit);
		$display("Verification failed");
		$finish;
	end

	task automatic load_vectors();
		int    fd;
		int    n;
		int    nm;
		int    ln;
		string line;
		nvec = 0;
		fd   = $fopen("testbench/command_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open testbench/command_input.txt");
		end else begin
			while (!$feof(fd) && nvec < MAX_VECS) begin
				line = "";
				n    = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %d %h %h %h %h %h %h %d %h %h %h %h %h %h %h",
						v_systime[nvec], nm, v_msg[nvec][0], v_msg[nvec][1], v_msg[nvec][2],
						v_msg[nvec][3], v_msg[nvec][4], v_msg[nvec][5], ln, v_ring[nvec][0],
						v_ring[nvec][1], v_ring[nvec][2], v_ring[nvec][3], v_ring[nvec][4],
						v_ring[nvec][5], v_gpio[nvec]);
					if (n != 16 || nm > 6 || ln > 6) begin
						errors++;
						$display("Malformed stimulus line: %s", line);
					end else begin
						v_nmsg[nvec] = nm;
						v_len[nvec]  = rsp_len_t'(ln);
						nvec++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int vec,
			input int pos);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: vector %0d ring byte %0d is %02h, expected %02h",
				$time, vec, pos, got, exp);
		end
	endtask

	task automatic check_len(input rsp_len_t got, input rsp_len_t exp, input int vec);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: vector %0d length is %0d, expected %0d", $time, vec, got, exp);
		end
	endtask

	task automatic check_gpio(input gpio_t got, input gpio_t exp, input int vec);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: vector %0d gpio is %02h, expected %02h", $time, vec, got, exp);
		end
	endtask

	task automatic compare_results(input int vec);
		int nring;
		nring = ring_q.size();
		if (len_q.size() != 0)
			check_len(len_q.pop_front(), v_len[vec], vec); // Zero expected means no write.
		if (len_q.size() != 0 || nring != v_len[vec]) begin
			errors++;
			$display("Vector %0d: %0d ring bytes written where %0d were expected, or extra lengths",
				vec, nring, v_len[vec]);
		end
		for (int k = 0; k < v_len[vec] && k < nring; k++)
			check_byte(ring_q[k], v_ring[vec][k], vec, k);
		ring_q.delete();
		len_q.delete();
		check_gpio(gpio, v_gpio[vec], vec);
	endtask

	initial begin
		rst_n     = 1'b0;
		msg_data  = 8'h00;
		msg_ready = 1'b0;
		systime   = '0;
		pop       = 1'b0;
		checks    = 0;
		errors    = 0;
		void'($urandom(32'he3beeac3));
		load_vectors();
		limit = RESET_CYCLES + 200 * nvec;
		repeat (RESET_CYCLES) @(posedge clk);
		#10;
		rst_n = 1'b1;
		for (int i = 0; i < nvec; i++) begin
			repeat ($urandom % 6) @(posedge clk); // Idle gap before the message.
			@(posedge clk);
			#10;
			systime = v_systime[i];
			@(negedge clk);
			for (int k = 0; k < v_nmsg[i]; k++)
				msg_q.push_back(v_msg[i][k]);
			if (v_len[i] != 0) begin
				while (len_q.size() == 0)
					@(negedge clk);
			end else begin
				repeat (40) @(negedge clk);
			end
			compare_results(i);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* source/command_top.sv */
`timescale 1ns/1ps

module command_top import command_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  msg_data,
	input  logic        msg_ready,
	output logic        msg_rd_en,
	input  logic [31:0] systime,
	output logic [7:0]  send_ring_data,
	output logic        send_ring_wr_en,
	output rsp_len_t    send_fifo_data,
	output logic        send_fifo_wr_en,
	output gpio_t       gpio
);

	cmd_t cmd;
	logic cmd_valid;
	logic cmd_take;
	logic shutdown;

	unit_if units [NUNITS] ();
	rsp_if  rsp ();

	vlq_decoder i_decoder (
		.clk, .rst_n, .msg_data, .msg_ready, .msg_rd_en,
		.cmd, .cmd_valid, .cmd_take
	);

	cmd_dispatcher i_dispatcher (
		.clk, .rst_n, .cmd, .cmd_valid, .cmd_take, .units(units), .rsp(rsp)
	);

	system_unit i_system (
		.clk, .rst_n, .bus(units[UNIT_SYSTEM]), .systime, .shutdown
	);

	gpio_unit i_gpio (
		.clk, .rst_n, .bus(units[UNIT_GPIO]), .shutdown, .gpio
	);

	vlq_encoder i_encoder (
		.clk, .rst_n, .rsp(rsp),
		.send_ring_data, .send_ring_wr_en, .send_fifo_data, .send_fifo_wr_en
	);

endmodule

/* source/vlq_encoder.sv */
`timescale 1ns/1ps

module vlq_encoder import command_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	rsp_if.encoder     rsp,
	output logic [7:0] send_ring_data,
	output logic       send_ring_wr_en,
	output rsp_len_t   send_fifo_data,
	output logic       send_fifo_wr_en
);

	typedef enum logic [1:0] {ST_IDLE, ST_ID, ST_PARAM, ST_LEN} state_t;

	state_t               state;
	arg_t                 params [MAX_PARAMS];
	logic [ARGS_BITS:0]   nparams;
	logic [ARGS_BITS-1:0] idx;
	logic [2:0]           cnt;   // Index of the next 7-bit group.
	logic [7:0]           rsp_id;
	rsp_len_t             len;
	logic [34:0]          cur;
	logic [7:0]           ring_byte;

	// Index of the top group left after dropping redundant leading groups.
	function automatic logic [2:0] last_group(arg_t p);
		logic [34:0] v;
		logic [8:0]  top;
		logic [2:0]  n;
		v = {{3{p[31]}}, p};
		n = 3'd4;
		for (int g = 4; g > 0; g--) begin
			top = v[7*g+6 -: 9];
			if (n == g && (top == 9'h1ff || top < 9'd3))
				n = 3'(g - 1);
		end
		return n;
	endfunction

	assign cur = {{3{params[idx][31]}}, params[idx]};

	always_comb begin
		if (state == ST_ID)
			ring_byte = rsp_id; // Id goes out raw.
		else
			ring_byte = {cnt != 3'd0, cur[7*cnt +: 7]};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state           <= ST_IDLE;
			nparams         <= '0;
			idx             <= '0;
			cnt             <= '0;
			len             <= '0;
			send_ring_wr_en <= 1'b0;
			send_fifo_wr_en <= 1'b0;
			rsp.rsp_busy    <= 1'b0;
		end else begin
			send_ring_wr_en <= 1'b0;
			send_fifo_wr_en <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rsp.rsp_write)
						nparams <= nparams + 1'b1;
					if (rsp.rsp_last) begin
						rsp.rsp_busy <= 1'b1;
						state        <= ST_ID;
					end
				end
				ST_ID: begin
					send_ring_wr_en <= 1'b1;
					len             <= rsp_len_t'(1);
					idx             <= '0;
					cnt             <= last_group(params[0]);
					state           <= (nparams == '0) ? ST_LEN : ST_PARAM;
				end
				ST_PARAM: begin
					send_ring_wr_en <= 1'b1;
					len             <= len + 1'b1;
					if (cnt != 3'd0) begin
						cnt <= cnt - 1'b1;
					end else if (idx + 1'b1 != nparams) begin
						idx <= idx + 1'b1;
						cnt <= last_group(params[idx + 1'b1]);
					end else begin
						state <= ST_LEN;
					end
				end
				default: begin
					send_fifo_wr_en <= 1'b1; // Length follows the last ring byte.
					rsp.rsp_busy    <= 1'b0;
					nparams         <= '0;
					state           <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rsp.rsp_write)
			params[nparams[ARGS_BITS-1:0]] <= rsp.rsp_param;
		if (rsp.rsp_last)
			rsp_id <= rsp.rsp_id;
		send_ring_data <= ring_byte;
		send_fifo_data <= len;
	end

	a_param_count: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.rsp_write |-> nparams < MAX_PARAMS);

endmodule

/* source/gpio_unit.sv */
`timescale 1ns/1ps

module gpio_unit import command_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	unit_if.unit  bus,
	input  logic  shutdown,
	output gpio_t gpio
);

	logic get_value; // Value argument is on arg_data.
	arg_t pin;

	assign bus.arg_advance = bus.cmd_ready && bus.cmd == CMD_SET_DIGITAL_OUT;
	assign bus.param_write = 1'b0;
	assign bus.param_data  = '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gpio         <= '0;
			get_value    <= 1'b0;
			bus.cmd_done <= 1'b0;
		end else begin
			bus.cmd_done <= get_value || (bus.cmd_ready && !bus.arg_advance);
			get_value    <= bus.arg_advance;
			// Negative pins compare as large and are dropped.
			if (get_value && !shutdown && $unsigned(pin) < NGPIO)
				gpio[pin[$clog2(NGPIO)-1:0]] <= bus.arg_data != 0;
			if (shutdown)
				gpio <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.cmd_ready)
			pin <= bus.arg_data;
	end

endmodule

/* source/system_unit.sv */
`timescale 1ns/1ps

module system_unit import command_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	unit_if.unit        bus,
	input  logic [31:0] systime,
	output logic        shutdown
);

	logic finish; // Parameter sent, response id follows.

	assign bus.arg_advance = 1'b0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus.param_write <= 1'b0;
			bus.cmd_done    <= 1'b0;
			finish          <= 1'b0;
			shutdown        <= 1'b0;
		end else begin
			bus.param_write <= 1'b0;
			bus.cmd_done    <= finish;
			finish          <= 1'b0;
			if (bus.cmd_ready) begin
				case (bus.cmd)
					CMD_GET_VERSION, CMD_GET_TIME: begin
						bus.param_write <= 1'b1;
						finish          <= 1'b1;
					end
					CMD_SHUTDOWN: begin
						shutdown     <= 1'b1; // Sticky until reset.
						bus.cmd_done <= 1'b1;
					end
					default: bus.cmd_done <= 1'b1;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.cmd_ready)
			bus.param_data <= (bus.cmd == CMD_GET_TIME) ? systime : VERSION;
		else if (finish)
			bus.param_data <= {24'd0, (bus.cmd == CMD_GET_TIME) ? RSP_GET_TIME : RSP_GET_VERSION};
	end

endmodule

/* source/cmd_dispatcher.sv */
`timescale 1ns/1ps

module cmd_dispatcher import command_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  cmd_t       cmd,
	input  logic       cmd_valid,
	output logic       cmd_take,
	unit_if.dispatcher units [NUNITS],
	rsp_if.dispatcher  rsp
);

	cmd_t                 cur; // Command in execution.
	logic                 busy;
	logic [NUNITS-1:0]    cmd_ready;
	logic [ARGS_BITS-1:0] arg_ptr;
	arg_t                 arg_data;
	logic [NUNITS-1:0]    arg_advance;
	logic [NUNITS-1:0]    param_write;
	logic [NUNITS-1:0]    cmd_done;
	arg_t                 param_data [NUNITS];
	unit_t                sel;

	assign sel = cur.entry.unit;

	for (genvar u = 0; u < NUNITS; u++) begin : g_unit
		assign units[u].cmd       = cur.id;
		assign units[u].cmd_ready = cmd_ready[u];
		assign units[u].arg_data  = arg_data;
		assign arg_advance[u]     = units[u].arg_advance;
		assign param_write[u]     = units[u].param_write;
		assign param_data[u]      = units[u].param_data;
		assign cmd_done[u]        = units[u].cmd_done;
	end

	// A command with a response waits for the encoder to drain.
	assign cmd_take = cmd_valid && !busy && !(cmd.entry.has_rsp && rsp.rsp_busy);

	assign rsp.rsp_param = param_data[sel];
	assign rsp.rsp_write = busy && cur.entry.has_rsp && param_write[sel];
	assign rsp.rsp_last  = busy && cur.entry.has_rsp && cmd_done[sel];
	assign rsp.rsp_id    = param_data[sel][7:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			cmd_ready <= '0;
			arg_ptr   <= '0;
		end else begin
			cmd_ready <= '0;
			if (cmd_take) begin
				busy                       <= 1'b1;
				cmd_ready[cmd.entry.unit]  <= 1'b1;
				arg_ptr                    <= ARGS_BITS'(1); // Argument 0 goes out with the start.
			end else if (busy) begin
				if (arg_advance[sel])
					arg_ptr <= arg_ptr + 1'b1;
				if (cmd_done[sel])
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_take) begin
			cur      <= cmd;
			arg_data <= cmd.args[0];
		end else if (busy && arg_advance[sel]) begin
			arg_data <= cur.args[arg_ptr];
		end
	end

	// A unit is started once and must finish before the next start.
	a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
		(|cmd_ready) |=> !(|cmd_ready) until cmd_done[sel]);

endmodule

/* source/vlq_decoder.sv */
`timescale 1ns/1ps

module vlq_decoder import command_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] msg_data,
	input  logic       msg_ready,
	output logic       msg_rd_en,
	output cmd_t       cmd,
	output logic       cmd_valid,
	input  logic       cmd_take
);

	typedef enum logic [1:0] {ST_ID, ST_ARG_START, ST_ARG_CONT} state_t;

	state_t               state;
	logic [ARGS_BITS-1:0] arg_idx;
	logic                 rd;
	logic                 last_arg;
	cmd_entry_t           entry;
	arg_t                 arg_next;

	// Hold off while a finished command waits for the dispatcher.
	assign rd       = msg_ready && !msg_rd_en && !cmd_valid;
	assign entry    = cmd_table[msg_data[CMD_BITS-1:0]];
	assign last_arg = arg_idx == cmd.entry.nargs - 1'b1;

	always_comb begin
		if (state == ST_ARG_CONT)
			arg_next = {cmd.args[arg_idx][24:0], msg_data[6:0]};
		else
			arg_next = {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]}; // Negative start.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_ID;
			arg_idx   <= '0;
			msg_rd_en <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			msg_rd_en <= rd;
			if (cmd_take)
				cmd_valid <= 1'b0;
			if (rd) begin
				if (state == ST_ID) begin
					arg_idx <= '0;
					if (entry.nargs == '0)
						cmd_valid <= 1'b1;
					else
						state <= ST_ARG_START;
				end else if (msg_data[7]) begin
					state <= ST_ARG_CONT; // More groups follow.
				end else if (last_arg) begin
					state     <= ST_ID;
					cmd_valid <= 1'b1;
				end else begin
					state   <= ST_ARG_START;
					arg_idx <= arg_idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd && state == ST_ID) begin
			cmd.id    <= msg_data[CMD_BITS-1:0];
			cmd.entry <= entry;
		end else if (rd) begin
			cmd.args[arg_idx] <= arg_next;
		end
	end

	a_single_read: assert property (@(posedge clk) disable iff (!rst_n)
		msg_rd_en |=> !msg_rd_en);

endmodule

/* source/rsp_if.sv */
`timescale 1ns/1ps

interface rsp_if import command_pkg::*; ();

	arg_t       rsp_param;
	logic       rsp_write;
	logic [7:0] rsp_id;
	logic       rsp_last; // Closes the response, rsp_id valid.
	logic       rsp_busy;

	modport dispatcher (
		output rsp_param, rsp_write, rsp_id, rsp_last,
		input  rsp_busy
	);

	modport encoder (
		input  rsp_param, rsp_write, rsp_id, rsp_last,
		output rsp_busy
	);

endinterface

/* source/unit_if.sv */
`timescale 1ns/1ps

interface unit_if import command_pkg::*; ();

	cmd_id_t cmd;
	logic    cmd_ready;   // Start strobe.
	arg_t    arg_data;
	logic    arg_advance; // Next argument wanted.
	logic    param_write;
	arg_t    param_data;  // Response id in the cmd_done cycle.
	logic    cmd_done;

	modport dispatcher (
		output cmd, cmd_ready, arg_data,
		input  arg_advance, param_write, param_data, cmd_done
	);

	modport unit (
		input  cmd, cmd_ready, arg_data,
		output arg_advance, param_write, param_data, cmd_done
	);

endinterface

/* source/command_pkg.sv */
package command_pkg;

	localparam int MAX_ARGS   = 8;
	localparam int ARGS_BITS  = 3;
	localparam int MAX_PARAMS = 8;
	localparam int CMD_BITS   = 5;
	localparam int NGPIO      = 8;
	localparam int NUNITS     = 2;

	typedef logic signed [31:0] arg_t;
	typedef logic [CMD_BITS-1:0] cmd_id_t;
	typedef logic [0:0] unit_t;
	typedef logic [NGPIO-1:0] gpio_t;
	typedef logic [7:0] rsp_len_t;

	localparam cmd_id_t CMD_GET_VERSION     = 5'd0;
	localparam cmd_id_t CMD_GET_TIME        = 5'd2;
	localparam cmd_id_t CMD_SET_DIGITAL_OUT = 5'd15;
	localparam cmd_id_t CMD_SHUTDOWN        = 5'd19;

	// First byte of a response, sent without VLQ coding.
	localparam logic [7:0] RSP_GET_VERSION = 8'd0;
	localparam logic [7:0] RSP_GET_TIME    = 8'd1;

	localparam logic [31:0] VERSION = 32'h0001_0203;

	localparam unit_t UNIT_SYSTEM = 1'b0;
	localparam unit_t UNIT_GPIO   = 1'b1;

	typedef struct packed {
		unit_t                unit;
		logic [ARGS_BITS-1:0] nargs;
		logic                 has_rsp; // Command answers with a response.
	} cmd_entry_t;

	typedef struct packed {
		cmd_id_t                   id;
		cmd_entry_t                entry;
		arg_t [MAX_ARGS-1:0]       args;
	} cmd_t;

	// Ids not listed run on the system unit with no arguments and no response.
	localparam cmd_entry_t cmd_table [2**CMD_BITS] = '{
		CMD_GET_VERSION:     '{UNIT_SYSTEM, 3'd0, 1'b1},
		CMD_GET_TIME:        '{UNIT_SYSTEM, 3'd0, 1'b1},
		CMD_SET_DIGITAL_OUT: '{UNIT_GPIO, 3'd2, 1'b0},
		CMD_SHUTDOWN:        '{UNIT_SYSTEM, 3'd0, 1'b0},
		default:             '0
	};

endpackage
